// File: verilog/huff_tree_pkg.sv
`default_nettype none

package huff_tree_pkg;

  // bit 8 set marks an internal node, clear marks a leaf carrying a character
  typedef logic [8:0] node_ref_t;

  // left child reference in the upper half, right child reference in the lower half
  typedef logic [17:0] node_word_t;

  typedef logic [6:0] node_addr_t; // the root always sits at address 0

  localparam int REF_INTERNAL_BIT = 8; // kind flag inside a node_ref_t

  localparam node_ref_t NULL_REF = 9'h180; // only used as the right child of a one-symbol root

  function automatic node_ref_t left_ref(input node_word_t word);
    return word[17:9];
  endfunction

  function automatic node_ref_t right_ref(input node_word_t word);
    return word[8:0];
  endfunction

endpackage

`default_nettype wire

// File: verilog/huff_code_pkg.sv
`default_nettype none

package huff_code_pkg;

  localparam int MAX_CODE_LEN = 16; // deepest leaf the codebook can hold
  localparam int NUM_CHARS = 256; // one table entry per byte value

  typedef logic [7:0] char_t;

  // code bits are right aligned, the first branch from the root is the top used bit
  typedef logic [15:0] code_t;

  typedef logic [4:0] code_len_t; // 0 means the entry is empty

  typedef logic [8:0] count_t; // up to 256 codebook entries

endpackage

`default_nettype wire

// File: verilog/tree_node_store.sv
`timescale 1ns/1ps
`default_nettype none

module tree_node_store #(
  parameter int NODE_AW = 7
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     node_wr,
  input  huff_tree_pkg::node_addr_t node_addr,
  input  huff_tree_pkg::node_word_t node_data,
  input  logic                     write_lock,
  input  logic                     rd_en,
  input  huff_tree_pkg::node_addr_t rd_addr,
  output huff_tree_pkg::node_word_t rd_data
);

  localparam int DEPTH = 1 << NODE_AW;

  huff_tree_pkg::node_word_t mem [DEPTH]; // tree nodes as written by the host

  logic host_wr_ok;

  assign host_wr_ok = node_wr && !write_lock; // the walker owns the tree while it runs

  always_ff @(posedge clk) begin
    if (host_wr_ok) begin
      mem[node_addr[NODE_AW-1:0]] <= node_data;
    end
  end

  // single cycle read latency, the walker samples rd_data in its decide cycle
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr[NODE_AW-1:0]];
    end
  end

  // upper address bits would silently alias onto low nodes
  a_wr_in_range: assert property (
    @(posedge clk) disable iff (rst)
    node_wr |-> ((node_addr >> NODE_AW) == '0)
  ) else $error("node write address 0x%0h beyond %0d entries", node_addr, DEPTH);

  // the walker should only follow references that the host could have written
  a_rd_in_range: assert property (
    @(posedge clk) disable iff (rst)
    rd_en |-> ((rd_addr >> NODE_AW) == '0)
  ) else $error("node read address 0x%0h beyond %0d entries", rd_addr, DEPTH);

endmodule

`default_nettype wire

// File: verilog/codebook_walker.sv
`timescale 1ns/1ps
`default_nettype none

module codebook_walker #(
  parameter int NODE_AW = 7
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  output logic                      busy,
  output logic                      done,
  output logic                      rd_en,
  output huff_tree_pkg::node_addr_t  rd_addr,
  input  huff_tree_pkg::node_word_t  rd_data,
  output logic                      clear,
  output logic                      code_wr,
  output huff_code_pkg::char_t       wr_char,
  output huff_code_pkg::code_t       wr_code,
  output huff_code_pkg::code_len_t   wr_len
);

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    DECIDE,
    EMIT,
    BACKTRACK,
    DONE
  } walk_state_t;

  walk_state_t state;

  huff_code_pkg::code_t     path; // branches from the root, newest one in bit 0
  huff_code_pkg::code_len_t depth; // number of valid bits in path
  huff_code_pkg::code_len_t pos; // tree level of the node being fetched
  logic [NODE_AW-1:0]       cur_addr; // node memory address of that node
  huff_code_pkg::char_t     leaf_char;

  logic [4:0]               bit_idx;
  logic                     at_last;
  logic                     branch;
  huff_tree_pkg::node_ref_t child;
  logic                     child_internal;

  // path bit that applies to the node at level pos
  assign bit_idx = depth - pos - 5'd1;
  assign at_last = (bit_idx == 5'd0); // this node is the end of the path, a new decision
  assign branch = path[bit_idx[3:0]];

  assign child = branch ? huff_tree_pkg::right_ref(rd_data) : huff_tree_pkg::left_ref(rd_data);
  assign child_internal = child[huff_tree_pkg::REF_INTERNAL_BIT];

  // The walker never keeps a node stack. After each leaf the path loses its trailing
  // right moves, its last left move turns right, and the tree is walked again from the root.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= IDLE;
      path     <= '0;
      depth    <= '0;
      pos      <= '0;
      cur_addr <= '0;
      clear    <= 1'b0;
    end else begin
      clear <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            state    <= FETCH;
            path     <= '0; // first decision is the root's left child
            depth    <= 5'd1;
            pos      <= '0;
            cur_addr <= '0;
            clear    <= 1'b1; // forget the codebook of the previous run
          end
        end
        FETCH: begin
          state <= DECIDE; // rd_data arrives in the next cycle
        end
        DECIDE: begin
          if (!at_last) begin
            cur_addr <= child[NODE_AW-1:0]; // re-tracing, the child was internal before
            pos      <= pos + 5'd1;
            state    <= FETCH;
          end else if (child == huff_tree_pkg::NULL_REF) begin
            state <= BACKTRACK; // missing right child of a one-symbol root
          end else if (child_internal) begin
            path     <= {path[14:0], 1'b0}; // go down and try its left side first
            depth    <= depth + 5'd1;
            cur_addr <= child[NODE_AW-1:0];
            pos      <= pos + 5'd1;
            state    <= FETCH;
          end else begin
            state <= EMIT;
          end
        end
        EMIT: begin
          state <= BACKTRACK;
        end
        BACKTRACK: begin
          if (path[0]) begin
            path  <= path >> 1; // right side already done, climb one level
            depth <= depth - 5'd1;
            if (depth == 5'd1) begin
              state <= DONE;
            end
          end else begin
            path[0]  <= 1'b1; // left subtree finished, take the right branch now
            pos      <= '0;
            cur_addr <= '0;
            state    <= FETCH;
          end
        end
        DONE: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == DECIDE) begin
      leaf_char <= child[7:0];
    end
  end

  assign busy    = (state != IDLE) && (state != DONE); // drops in the done cycle
  assign done    = (state == DONE);
  assign rd_en   = (state == FETCH);
  assign rd_addr = huff_tree_pkg::node_addr_t'(cur_addr);
  assign code_wr = (state == EMIT);
  assign wr_char = leaf_char;
  assign wr_code = path;
  assign wr_len  = depth;

  // a deeper tree would push code bits out of the top of path
  a_depth_limit: assert property (
    @(posedge clk) disable iff (rst)
    depth <= huff_code_pkg::MAX_CODE_LEN
  ) else $error("walk depth %0d beyond the supported code length", depth);

  // every table write belongs to a running walk and carries a real length
  a_wr_while_busy: assert property (
    @(posedge clk) disable iff (rst)
    code_wr |-> (busy && wr_len != '0)
  ) else $error("code write outside an active walk");

endmodule

`default_nettype wire

// File: verilog/code_table.sv
`timescale 1ns/1ps
`default_nettype none

module code_table (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clear,
  input  logic                    code_wr,
  input  huff_code_pkg::char_t     wr_char,
  input  huff_code_pkg::code_t     wr_code,
  input  huff_code_pkg::code_len_t wr_len,
  input  huff_code_pkg::char_t     lookup_char,
  output huff_code_pkg::code_t     lookup_code,
  output huff_code_pkg::code_len_t lookup_len,
  output logic                    lookup_valid,
  output huff_code_pkg::count_t    entry_count
);

  huff_code_pkg::code_t     code_mem [huff_code_pkg::NUM_CHARS];
  huff_code_pkg::code_len_t len_mem  [huff_code_pkg::NUM_CHARS]; // zero marks an empty entry

  // code bits are only meaningful where the length is nonzero
  always_ff @(posedge clk) begin
    if (code_wr && !clear) begin
      code_mem[wr_char] <= wr_code;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < huff_code_pkg::NUM_CHARS; i++) begin
        len_mem[i] <= '0;
      end
      entry_count <= '0;
    end else if (clear) begin
      for (int i = 0; i < huff_code_pkg::NUM_CHARS; i++) begin
        len_mem[i] <= '0; // a new run starts from an empty codebook
      end
      entry_count <= '0;
    end else if (code_wr) begin
      len_mem[wr_char] <= wr_len;
      entry_count      <= entry_count + 9'd1;
    end
  end

  assign lookup_code  = code_mem[lookup_char];
  assign lookup_len   = len_mem[lookup_char];
  assign lookup_valid = (len_mem[lookup_char] != '0);

  // a character appears at most once in a tree, so a second write means a broken walk
  a_single_write: assert property (
    @(posedge clk) disable iff (rst)
    (code_wr && !clear) |-> (len_mem[wr_char] == '0)
  ) else $error("character 0x%0h written twice since the last clear", wr_char);

  // all 256 entries filled is the most one run can produce
  a_count_limit: assert property (
    @(posedge clk) disable iff (rst)
    (code_wr && !clear) |-> (entry_count < 9'(huff_code_pkg::NUM_CHARS))
  ) else $error("codebook entry count overflow");

endmodule

`default_nettype wire

// File: verilog/huff_codebook_top.sv
`timescale 1ns/1ps
`default_nettype none

module huff_codebook_top #(
  parameter int NODE_AW = 7
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      node_wr,
  input  huff_tree_pkg::node_addr_t  node_addr,
  input  huff_tree_pkg::node_word_t  node_data,
  input  logic                      start,
  input  huff_code_pkg::char_t       lookup_char,
  output logic                      busy,
  output logic                      done,
  output huff_code_pkg::count_t      entry_count,
  output huff_code_pkg::code_t       lookup_code,
  output huff_code_pkg::code_len_t   lookup_len,
  output logic                      lookup_valid
);

  logic                     rd_en;
  huff_tree_pkg::node_addr_t rd_addr;
  huff_tree_pkg::node_word_t rd_data;
  logic                     clear;
  logic                     code_wr;
  huff_code_pkg::char_t      wr_char;
  huff_code_pkg::code_t      wr_code;
  huff_code_pkg::code_len_t  wr_len;

  tree_node_store #(
    .NODE_AW(NODE_AW)
  ) u_tree_node_store (
    .clk       (clk),
    .rst       (rst),
    .node_wr   (node_wr),
    .node_addr (node_addr),
    .node_data (node_data),
    .write_lock(busy), // the tree stays fixed while the walker reads it
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  codebook_walker #(
    .NODE_AW(NODE_AW)
  ) u_codebook_walker (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .busy   (busy),
    .done   (done),
    .rd_en  (rd_en),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .clear  (clear),
    .code_wr(code_wr),
    .wr_char(wr_char),
    .wr_code(wr_code),
    .wr_len (wr_len)
  );

  code_table u_code_table (
    .clk         (clk),
    .rst         (rst),
    .clear       (clear),
    .code_wr     (code_wr),
    .wr_char     (wr_char),
    .wr_code     (wr_code),
    .wr_len      (wr_len),
    .lookup_char (lookup_char),
    .lookup_code (lookup_code),
    .lookup_len  (lookup_len),
    .lookup_valid(lookup_valid),
    .entry_count (entry_count)
  );

endmodule

`default_nettype wire

// File: dv/huff_codebook_tb.sv
`timescale 1ns/1ps
`default_nettype none

module huff_codebook_tb;

  localparam int NUM_TREES = 20;
  localparam int MAX_LEAVES = 40;
  localparam int TIMEOUT_CYCLES = NUM_TREES * 4000; // per tree bound that covers walk and lookups
  localparam logic [31:0] SEED = 32'h5d28_5cb4;

  logic clk;
  logic rst;
  logic node_wr;
  huff_tree_pkg::node_addr_t node_addr;
  huff_tree_pkg::node_word_t node_data;
  logic start;
  huff_code_pkg::char_t lookup_char;
  logic busy;
  logic done;
  huff_code_pkg::count_t entry_count;
  huff_code_pkg::code_t lookup_code;
  huff_code_pkg::code_len_t lookup_len;
  logic lookup_valid;

  logic [31:0] lfsr_state;
  logic [17:0] node_img [128]; // tree image in the same layout the host writes
  int node_cnt;
  int leaf_cnt;
  int exp_len [256]; // reference codebook, length 0 means unused character
  logic [15:0] exp_code [256];
  logic [7:0] perm [256];
  int done_count;
  int cycle_count = 0;

  huff_codebook_top #(
    .NODE_AW(7)
  ) u_huff_codebook_top (
    .clk         (clk),
    .rst         (rst),
    .node_wr     (node_wr),
    .node_addr   (node_addr),
    .node_data   (node_data),
    .start       (start),
    .lookup_char (lookup_char),
    .busy        (busy),
    .done        (done),
    .entry_count (entry_count),
    .lookup_code (lookup_code),
    .lookup_len  (lookup_len),
    .lookup_valid(lookup_valid)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      done_count <= 0;
    end else if (done) begin
      done_count <= done_count + 1; // every done pulse is counted, wanted or not
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%0h expected 0x%0h", name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // taps 32, 22, 2, 1 of a Fibonacci shift register
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int rand_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state); // one step per bit taken
      r = (r << 1) | int'(lfsr_state[0]);
    end
    return r;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + (rand_bits(16) % (hi - lo + 1));
  endfunction

  task automatic clear_model();
    for (int c = 0; c < 256; c++) begin
      exp_len[c] = 0;
      exp_code[c] = '0;
    end
    leaf_cnt = 0;
  endtask

  // Builds a tree of n leaves by splitting leaf counts at random. Each pending subtree
  // keeps its node address, leaf count, level and path, so the model code falls out directly.
  task automatic build_tree(input int n);
    int q_addr [$];
    int q_k [$];
    int q_depth [$];
    int q_code [$];
    int addr, k, d, code, cap, lo, hi, ks, child_code, leaf_idx, j;
    logic [8:0] refs [2];
    logic [7:0] tmp;
    clear_model();
    for (int i = 0; i < 256; i++) begin
      perm[i] = 8'(i);
    end
    for (int i = 0; i < n; i++) begin
      j = rand_range(i, 255); // partial shuffle picks n distinct characters
      tmp = perm[i];
      perm[i] = perm[j];
      perm[j] = tmp;
    end
    leaf_idx = 0;
    node_cnt = 1;
    if (n == 1) begin
      node_img[0] = {1'b0, perm[0], huff_tree_pkg::NULL_REF};
      exp_len[perm[0]] = 1;
      leaf_cnt = 1;
    end else begin
      q_addr.push_back(0);
      q_k.push_back(n);
      q_depth.push_back(0);
      q_code.push_back(0);
      while (q_addr.size() > 0) begin
        addr = q_addr.pop_front();
        k = q_k.pop_front();
        d = q_depth.pop_front();
        code = q_code.pop_front();
        cap = 1 << (15 - d); // most leaves a child subtree can hold within 16 levels
        lo = (k - cap > 1) ? k - cap : 1;
        hi = (k - 1 < cap) ? k - 1 : cap;
        ks = rand_range(lo, hi);
        for (int side = 0; side < 2; side++) begin
          child_code = (code << 1) | side;
          if (ks == 1) begin
            refs[side] = {1'b0, perm[leaf_idx]};
            exp_len[perm[leaf_idx]] = d + 1;
            exp_code[perm[leaf_idx]] = 16'(child_code);
            leaf_idx++;
          end else begin
            refs[side] = 9'h100 | 9'(node_cnt);
            q_addr.push_back(node_cnt);
            q_k.push_back(ks);
            q_depth.push_back(d + 1);
            q_code.push_back(child_code);
            node_cnt++;
          end
          ks = k - ks; // right side takes the remaining leaves
        end
        node_img[addr] = {refs[0], refs[1]};
      end
      leaf_cnt = n;
    end
  endtask

  task automatic load_tree();
    for (int i = 0; i < node_cnt; i++) begin
      @(posedge clk);
      node_wr <= 1'b1;
      node_addr <= 7'(i);
      node_data <= node_img[i];
    end
    @(posedge clk);
    node_wr <= 1'b0;
  endtask

  // poke sends a second start and a root overwrite while the walk runs
  task automatic run_walk(input bit poke);
    int done_before;
    done_before = done_count;
    check_value("busy", busy, 1'b0);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(posedge clk);
    check_value("busy", busy, 1'b1); // high in the cycle after start
    if (poke) begin
      start <= 1'b1;
      node_wr <= 1'b1;
      node_addr <= '0;
      node_data <= {1'b0, 8'(rand_bits(8)), 1'b0, 8'(rand_bits(8))};
      @(posedge clk);
      start <= 1'b0;
      node_wr <= 1'b0;
    end
    do begin
      @(posedge clk);
    end while (done !== 1'b1);
    check_value("busy", busy, 1'b0);
    repeat (3) @(posedge clk);
    check_value("done_count", done_count, done_before + 1);
    check_value("busy", busy, 1'b0);
  endtask

  task automatic check_codebook();
    for (int c = 0; c < 256; c++) begin
      @(posedge clk);
      lookup_char <= 8'(c);
      @(negedge clk);
      if (exp_len[c] != 0) begin
        check_value("lookup_valid", lookup_valid, 1'b1);
        check_value("lookup_len", lookup_len, exp_len[c]);
        check_value("lookup_code", lookup_code, exp_code[c]);
      end else begin
        check_value("lookup_valid", lookup_valid, 1'b0);
        check_value("lookup_len", lookup_len, 0);
      end
    end
    check_value("entry_count", entry_count, leaf_cnt);
  endtask

  initial begin
    int n;
    clk = 1'b0;
    rst = 1'b1;
    node_wr = 1'b0;
    node_addr = '0;
    node_data = '0;
    start = 1'b0;
    lookup_char = '0;
    lfsr_state = SEED;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    clear_model();
    check_codebook(); // nothing valid right after reset
    for (int t = 0; t < NUM_TREES; t++) begin
      n = (t == 0) ? 1 : rand_range(1, MAX_LEAVES);
      build_tree(n);
      load_tree();
      run_walk(t % 2 == 1);
      check_codebook();
      if (t == 0) begin
        @(posedge clk);
        lookup_char <= perm[0];
        @(negedge clk);
        check_value("lookup_len", lookup_len, 1);
        check_value("lookup_code", lookup_code, 0);
        check_value("entry_count", entry_count, 1);
      end
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
verilog/huff_tree_pkg.sv
verilog/huff_code_pkg.sv
verilog/tree_node_store.sv
verilog/codebook_walker.sv
verilog/code_table.sv
verilog/huff_codebook_top.sv
dv/huff_codebook_tb.sv
